/* logic/lsq_macros.svh */
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// load and store queue sizing
`define LSQ_DEPTH       16
`define LSQ_INDEX_W     4

// front end and retire widths
`define DISPATCH_LANES  2
`define COMMIT_LANES    2

// address split, byte offset inside a 32-bit word
`define ADDR_W          32
`define BYTE_OFF_W      2

// back end tag widths
`define ALID_W          7
`define PHYREG_W        7

`endif

/* logic/memAccessPkg.sv */
`include "lsq_macros.svh"

package memAccessPkg;

	// word-aligned part and byte offset of one address
	typedef struct packed
	{
		logic [`ADDR_W-`BYTE_OFF_W-1:0] wordIdx;
		logic [`BYTE_OFF_W-1:0]         byteOff;
	} memAddrSplitT;

	// same address word, read flat or split
	typedef union packed
	{
		logic [`ADDR_W-1:0] flat;
		memAddrSplitT       split;
	} memAddrT;

	// access width, ordered so a larger value covers more bytes
	typedef enum logic [1:0]
	{
		sizeByte = 2'd0,
		sizeHalf = 2'd1,
		sizeWord = 2'd2
	} accessSizeT;

endpackage

/* logic/ldqPkg.sv */
`include "lsq_macros.svh"

package ldqPkg;

	// slot number in the load or store queue
	typedef logic [`LSQ_INDEX_W-1:0] lsqIdxT;

	// occupancy, one extra bit so a full queue is distinct from empty
	typedef logic [`LSQ_INDEX_W:0] lsqCountT;

	// active list tag of an in-flight instruction
	typedef logic [`ALID_W-1:0] alIdT;

	// renamed destination register
	typedef logic [`PHYREG_W-1:0] phyRegT;

endpackage

/* logic/ldqAddrCam.sv */
`timescale 1ns/100ps
`include "lsq_macros.svh"

module ldqAddrCam
	import memAccessPkg::*, ldqPkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   recoverFlag_i,
	input  logic                   wrEn_i,
	input  lsqIdxT                 wrIdx_i,
	input  memAddrT                wrAddr_i,
	input  memAddrT                stAddr_i,
	input  lsqIdxT                 rdIdx_i,
	output memAddrT                rdAddr_o,
	output logic [`LSQ_DEPTH-1:0]  wordMatch_o,
	output logic [`LSQ_DEPTH-1:0]  halfMatch_o,
	output logic [`LSQ_DEPTH-1:0]  byteMatch_o
);

	// address kept in two fields, matched separately
	logic [`ADDR_W-`BYTE_OFF_W-1:0] wordMem [`LSQ_DEPTH];
	logic [`BYTE_OFF_W-1:0]         offMem  [`LSQ_DEPTH];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset || recoverFlag_i)
		begin
			// squash wipes every stored address
			for (int i = 0; i < `LSQ_DEPTH; i++)
			begin
				wordMem[i] <= '0;
				offMem[i]  <= '0;
			end
		end
		else if (wrEn_i)
		begin
			wordMem[wrIdx_i] <= wrAddr_i.split.wordIdx;
			offMem[wrIdx_i]  <= wrAddr_i.split.byteOff;
		end
	end

	// replay port, rebuilt as one flat word
	assign rdAddr_o.flat = {wordMem[rdIdx_i], offMem[rdIdx_i]};

	// store address against every entry
	always_comb
	begin
		for (int i = 0; i < `LSQ_DEPTH; i++)
		begin
			wordMatch_o[i] = (wordMem[i] == stAddr_i.split.wordIdx);
			// upper offset bit picks the half inside the word
			halfMatch_o[i] = (offMem[i][1] == stAddr_i.split.byteOff[1]);
			// lower offset bit picks the byte inside the half
			byteMatch_o[i] = (offMem[i][0] == stAddr_i.split.byteOff[0]);
		end
	end

endmodule

/* logic/ldqStatus.sv */
`timescale 1ns/100ps
`include "lsq_macros.svh"

module ldqStatus
	import memAccessPkg::*, ldqPkg::*;
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 recoverFlag_i,
	input  logic                                 ldValid_i,
	input  lsqIdxT                               ldLsqId_i,
	input  accessSizeT                           ldSize_i,
	input  logic                                 loadDataValid_i,
	input  logic                                 backEndReady_i,
	input  logic [`DISPATCH_LANES-1:0]           dispIsLoad_i,
	input  lsqIdxT                               dispLdqId_i [`DISPATCH_LANES],
	input  logic [$clog2(`COMMIT_LANES+1)-1:0]   commitLdCount_i,
	input  lsqIdxT                               commitLdIndex_i [`COMMIT_LANES],
	input  lsqIdxT                               headIdx_i,
	output logic [`LSQ_DEPTH-1:0]                addrValid_o,
	output logic [`LSQ_DEPTH-1:0]                writtenBack_o,
	output accessSizeT                           sizes_o [`LSQ_DEPTH],
	output logic                                 replayValid_o,
	output accessSizeT                           replaySize_o
);

	logic [`LSQ_DEPTH-1:0] addrValidQ;
	logic [`LSQ_DEPTH-1:0] writtenBackQ;
	accessSizeT            sizeQ [`LSQ_DEPTH];

	// later assignments in this block take priority
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset || recoverFlag_i)
		begin
			// recovery beats everything on the same edge
			addrValidQ   <= '0;
			writtenBackQ <= '0;
			for (int i = 0; i < `LSQ_DEPTH; i++)
			begin
				sizeQ[i] <= sizeByte;
			end
		end
		else
		begin
			// executed load, first or replayed
			if (ldValid_i)
			begin
				sizeQ[ldLsqId_i]        <= ldSize_i;
				addrValidQ[ldLsqId_i]   <= 1'b1;
				writtenBackQ[ldLsqId_i] <= loadDataValid_i;
			end

			// a newly dispatched load starts clean
			if (backEndReady_i)
			begin
				for (int l = 0; l < `DISPATCH_LANES; l++)
				begin
					if (dispIsLoad_i[l])
					begin
						addrValidQ[dispLdqId_i[l]]   <= 1'b0;
						writtenBackQ[dispLdqId_i[l]] <= 1'b0;
					end
				end
			end

			// retiring loads, lanes below the count only
			for (int l = 0; l < `COMMIT_LANES; l++)
			begin
				if (l < int'(commitLdCount_i))
				begin
					addrValidQ[commitLdIndex_i[l]]   <= 1'b0;
					writtenBackQ[commitLdIndex_i[l]] <= 1'b0;
				end
			end
		end
	end

	assign addrValid_o   = addrValidQ;
	assign writtenBack_o = writtenBackQ;
	assign sizes_o       = sizeQ;

	// head load has an address but never got its data
	assign replayValid_o = addrValidQ[headIdx_i] & ~writtenBackQ[headIdx_i];
	assign replaySize_o  = sizeQ[headIdx_i];

endmodule

/* logic/ldqPayloadRam.sv */
`timescale 1ns/100ps
`include "lsq_macros.svh"

module ldqPayloadRam
	import ldqPkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   wrEn_i,
	input  lsqIdxT wrIdx_i,
	input  alIdT   wrAlId_i,
	input  phyRegT wrPhyDest_i,
	input  lsqIdxT rdHeadIdx_i,
	output alIdT   headAlId_o,
	output phyRegT headPhyDest_o,
	input  lsqIdxT rdVioIdx_i,
	output alIdT   vioAlId_o
);

	alIdT   alIdMem    [`LSQ_DEPTH];
	phyRegT phyDestMem [`LSQ_DEPTH];

	// contents survive recovery, entries get rewritten on the next execute
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `LSQ_DEPTH; i++)
			begin
				alIdMem[i]    <= '0;
				phyDestMem[i] <= '0;
			end
		end
		else if (wrEn_i)
		begin
			alIdMem[wrIdx_i]    <= wrAlId_i;
			phyDestMem[wrIdx_i] <= wrPhyDest_i;
		end
	end

	// port 0 feeds the replay packet
	assign headAlId_o    = alIdMem[rdHeadIdx_i];
	assign headPhyDest_o = phyDestMem[rdHeadIdx_i];

	// port 1 tags the violating load
	assign vioAlId_o = alIdMem[rdVioIdx_i];

endmodule

/* logic/followingLoadRam.sv */
`timescale 1ns/100ps
`include "lsq_macros.svh"

module followingLoadRam
	import ldqPkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       recoverFlag_i,
	input  logic                       backEndReady_i,
	input  logic [`DISPATCH_LANES-1:0] dispIsStore_i,
	input  lsqIdxT                     dispStqId_i  [`DISPATCH_LANES],
	input  lsqIdxT                     dispNextLd_i [`DISPATCH_LANES],
	input  lsqIdxT                     rdIdx_i,
	output lsqIdxT                     nextLoad_o
);

	// one slot per store queue entry
	lsqIdxT nextLdMem [`LSQ_DEPTH];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset || recoverFlag_i)
		begin
			for (int i = 0; i < `LSQ_DEPTH; i++)
			begin
				nextLdMem[i] <= '0;
			end
		end
		else if (backEndReady_i)
		begin
			// one write port per dispatch lane
			for (int l = 0; l < `DISPATCH_LANES; l++)
			begin
				if (dispIsStore_i[l])
				begin
					nextLdMem[dispStqId_i[l]] <= dispNextLd_i[l];
				end
			end
		end
	end

	// looked up by the executing store
	assign nextLoad_o = nextLdMem[rdIdx_i];

endmodule

/* logic/violationDetect.sv */
`timescale 1ns/100ps
`include "lsq_macros.svh"

module violationDetect
	import memAccessPkg::*, ldqPkg::*;
(
	input  logic                  stValid_i,
	input  accessSizeT            stSize_i,
	input  lsqIdxT                nextLoad_i,
	input  lsqIdxT                ldqHead_i,
	input  lsqIdxT                ldqTail_i,
	input  lsqCountT              ldqCount_i,
	input  logic [`LSQ_DEPTH-1:0] addrValid_i,
	input  logic [`LSQ_DEPTH-1:0] writtenBack_i,
	input  accessSizeT            sizes_i [`LSQ_DEPTH],
	input  logic [`LSQ_DEPTH-1:0] wordMatch_i,
	input  logic [`LSQ_DEPTH-1:0] halfMatch_i,
	input  logic [`LSQ_DEPTH-1:0] byteMatch_i,
	output logic                  vioValid_o,
	output lsqIdxT                vioIdx_o
);

	logic                  ldqWrap;
	logic                  fullWindow;
	logic [`LSQ_DEPTH-1:0] window;
	accessSizeT            maxSize [`LSQ_DEPTH];
	logic [`LSQ_DEPTH-1:0] overlap;
	logic [`LSQ_DEPTH-1:0] violate;
	logic                  hit;

	// loads younger than the store sit in [nextLoad, tail)
	assign ldqWrap    = (ldqTail_i < nextLoad_i);
	// tail caught up with head, queue is full of younger loads
	assign fullWindow = (ldqTail_i == nextLoad_i) && (ldqHead_i == nextLoad_i)
		&& (ldqCount_i != '0);

	always_comb
	begin
		for (int i = 0; i < `LSQ_DEPTH; i++)
		begin
			if (ldqWrap)
				window[i] = (lsqIdxT'(i) >= nextLoad_i) || (lsqIdxT'(i) < ldqTail_i);
			else
				window[i] = (lsqIdxT'(i) >= nextLoad_i) && (lsqIdxT'(i) < ldqTail_i);
			window[i] = window[i] | fullWindow;
		end
	end

	// wider of the two accesses decides how many offset bits matter
	always_comb
	begin
		for (int i = 0; i < `LSQ_DEPTH; i++)
		begin
			maxSize[i] = (stSize_i > sizes_i[i]) ? stSize_i : sizes_i[i];
			case (maxSize[i])
				sizeByte: overlap[i] = wordMatch_i[i] & halfMatch_i[i] & byteMatch_i[i];
				sizeHalf: overlap[i] = wordMatch_i[i] & halfMatch_i[i];
				default:  overlap[i] = wordMatch_i[i];
			endcase
		end
	end

	// only loads that already returned data can be wrong
	assign violate = window & overlap & addrValid_i & writtenBack_i;

	// circular scan from nextLoad, oldest violator wins
	always_comb
	begin
		hit      = 1'b0;
		vioIdx_o = nextLoad_i;
		for (int j = 0; j < `LSQ_DEPTH; j++)
		begin
			if (!hit && violate[lsqIdxT'(nextLoad_i + lsqIdxT'(j))])
			begin
				hit      = 1'b1;
				vioIdx_o = lsqIdxT'(nextLoad_i + lsqIdxT'(j));
			end
		end
	end

	assign vioValid_o = stValid_i & hit;

endmodule

/* logic/storeExecPath.sv */
`timescale 1ns/100ps
`include "lsq_macros.svh"

module storeExecPath
	import memAccessPkg::*, ldqPkg::*;
(
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               recoverFlag_i,
	input  logic                               backEndReady_i,
	// load execute
	input  logic                               ldValid_i,
	input  lsqIdxT                             ldLsqId_i,
	input  memAddrT                            ldAddr_i,
	input  accessSizeT                         ldSize_i,
	input  alIdT                               ldAlId_i,
	input  phyRegT                             ldPhyDest_i,
	input  logic                               loadDataValid_i,
	// store execute
	input  logic                               stValid_i,
	input  lsqIdxT                             stLsqId_i,
	input  memAddrT                            stAddr_i,
	input  accessSizeT                         stSize_i,
	// dispatch lanes
	input  logic [`DISPATCH_LANES-1:0]         dispIsLoad_i,
	input  logic [`DISPATCH_LANES-1:0]         dispIsStore_i,
	input  lsqIdxT                             dispLdqId_i  [`DISPATCH_LANES],
	input  lsqIdxT                             dispStqId_i  [`DISPATCH_LANES],
	input  lsqIdxT                             dispNextLd_i [`DISPATCH_LANES],
	// commit lanes
	input  logic [$clog2(`COMMIT_LANES+1)-1:0] commitLdCount_i,
	input  lsqIdxT                             commitLdIndex_i [`COMMIT_LANES],
	// queue pointers
	input  lsqIdxT                             ldqHead_i,
	input  lsqIdxT                             ldqTail_i,
	input  lsqCountT                           ldqCount_i,
	// replay packet
	output logic                               replayValid_o,
	output lsqIdxT                             replayLsqId_o,
	output memAddrT                            replayAddr_o,
	output accessSizeT                         replaySize_o,
	output alIdT                               replayAlId_o,
	output phyRegT                             replayPhyDest_o,
	// ordering violation
	output logic                               vioValid_o,
	output alIdT                               vioAlId_o
);

	logic [`LSQ_DEPTH-1:0] wordMatch;
	logic [`LSQ_DEPTH-1:0] halfMatch;
	logic [`LSQ_DEPTH-1:0] byteMatch;
	logic [`LSQ_DEPTH-1:0] addrValid;
	logic [`LSQ_DEPTH-1:0] writtenBack;
	accessSizeT            sizes [`LSQ_DEPTH];
	lsqIdxT                nextLoad;
	lsqIdxT                vioIdx;

	// replay always comes from the queue head
	assign replayLsqId_o = ldqHead_i;

	ldqAddrCam addrCam (
		.clk           (clk),
		.reset         (reset),
		.recoverFlag_i (recoverFlag_i),
		.wrEn_i        (ldValid_i),
		.wrIdx_i       (ldLsqId_i),
		.wrAddr_i      (ldAddr_i),
		.stAddr_i      (stAddr_i),
		.rdIdx_i       (ldqHead_i),
		.rdAddr_o      (replayAddr_o),
		.wordMatch_o   (wordMatch),
		.halfMatch_o   (halfMatch),
		.byteMatch_o   (byteMatch)
	);

	ldqStatus status (
		.clk             (clk),
		.reset           (reset),
		.recoverFlag_i   (recoverFlag_i),
		.ldValid_i       (ldValid_i),
		.ldLsqId_i       (ldLsqId_i),
		.ldSize_i        (ldSize_i),
		.loadDataValid_i (loadDataValid_i),
		.backEndReady_i  (backEndReady_i),
		.dispIsLoad_i    (dispIsLoad_i),
		.dispLdqId_i     (dispLdqId_i),
		.commitLdCount_i (commitLdCount_i),
		.commitLdIndex_i (commitLdIndex_i),
		.headIdx_i       (ldqHead_i),
		.addrValid_o     (addrValid),
		.writtenBack_o   (writtenBack),
		.sizes_o         (sizes),
		.replayValid_o   (replayValid_o),
		.replaySize_o    (replaySize_o)
	);

	// second read port follows the violation search
	ldqPayloadRam payloadRam (
		.clk           (clk),
		.reset         (reset),
		.wrEn_i        (ldValid_i),
		.wrIdx_i       (ldLsqId_i),
		.wrAlId_i      (ldAlId_i),
		.wrPhyDest_i   (ldPhyDest_i),
		.rdHeadIdx_i   (ldqHead_i),
		.headAlId_o    (replayAlId_o),
		.headPhyDest_o (replayPhyDest_o),
		.rdVioIdx_i    (vioIdx),
		.vioAlId_o     (vioAlId_o)
	);

	followingLoadRam followingLd (
		.clk            (clk),
		.reset          (reset),
		.recoverFlag_i  (recoverFlag_i),
		.backEndReady_i (backEndReady_i),
		.dispIsStore_i  (dispIsStore_i),
		.dispStqId_i    (dispStqId_i),
		.dispNextLd_i   (dispNextLd_i),
		.rdIdx_i        (stLsqId_i),
		.nextLoad_o     (nextLoad)
	);

	violationDetect vioDetect (
		.stValid_i     (stValid_i),
		.stSize_i      (stSize_i),
		.nextLoad_i    (nextLoad),
		.ldqHead_i     (ldqHead_i),
		.ldqTail_i     (ldqTail_i),
		.ldqCount_i    (ldqCount_i),
		.addrValid_i   (addrValid),
		.writtenBack_i (writtenBack),
		.sizes_i       (sizes),
		.wordMatch_i   (wordMatch),
		.halfMatch_i   (halfMatch),
		.byteMatch_i   (byteMatch),
		.vioValid_o    (vioValid_o),
		.vioIdx_o      (vioIdx)
	);

endmodule

/* test/clockGen.sv */
`timescale 1ns/100ps

module clockGen
(
	output logic clk,
	output logic reset
);

	// 10 ns period
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// held over three rising edges, released just after the third
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

/* test/storeExecPath_checker.sv */
`timescale 1ns/100ps

module storeExecPath_checker
(
	input logic clk,
	input logic reset,
	input logic recoverFlag_i,
	input logic stValid_i,
	input logic replayValid_i,
	input logic vioValid_i
);

	// queue leaves reset empty, nothing to replay or flag
	resetLeavesQuiet: assert property (@(posedge clk)
		reset |=> !replayValid_i && !vioValid_i)
	else $error("replay or violation raised in the cycle after reset");

	// squash wipes every load, same picture as after reset
	recoverLeavesQuiet: assert property (@(posedge clk) disable iff (reset)
		recoverFlag_i |=> !replayValid_i && !vioValid_i)
	else $error("replay or violation raised in the cycle after recovery");

	// a violation only exists while a store executes
	vioNeedsStore: assert property (@(posedge clk) disable iff (reset)
		vioValid_i |-> stValid_i)
	else $error("violation reported without an executing store");

endmodule

/* test/storeExecPath_tb.sv */
`timescale 1ns/100ps
`include "lsq_macros.svh"

module storeExecPath_tb
	import memAccessPkg::*, ldqPkg::*;
();

	typedef logic [$clog2(`COMMIT_LANES+1)-1:0] commitCountT;

	logic clk;
	logic reset;
	logic recoverFlag;
	logic backEndReady;
	logic ldValid;
	logic loadDataValid;
	logic stValid;
	lsqIdxT ldLsqId;
	lsqIdxT stLsqId;
	memAddrT ldAddr;
	memAddrT stAddr;
	accessSizeT ldSize;
	accessSizeT stSize;
	alIdT ldAlId;
	phyRegT ldPhyDest;
	logic [`DISPATCH_LANES-1:0] dispIsLoad;
	logic [`DISPATCH_LANES-1:0] dispIsStore;
	lsqIdxT dispLdqId [`DISPATCH_LANES];
	lsqIdxT dispStqId [`DISPATCH_LANES];
	lsqIdxT dispNextLd [`DISPATCH_LANES];
	commitCountT commitLdCount;
	lsqIdxT commitLdIndex [`COMMIT_LANES];
	lsqIdxT ldqHead;
	lsqIdxT ldqTail;
	lsqCountT ldqCount;
	logic replayValid;
	lsqIdxT replayLsqId;
	memAddrT replayAddr;
	accessSizeT replaySize;
	alIdT replayAlId;
	phyRegT replayPhyDest;
	logic vioValid;
	alIdT vioAlId;

	// reference copy of the load queue and following-load table
	logic [`LSQ_DEPTH-1:0] mAddrValid;
	logic [`LSQ_DEPTH-1:0] mWrittenBack;
	logic [`ADDR_W-1:0] mAddr [`LSQ_DEPTH];
	accessSizeT mSize [`LSQ_DEPTH];
	alIdT mAlId [`LSQ_DEPTH];
	phyRegT mPhyDest [`LSQ_DEPTH];
	lsqIdxT mNextLd [`LSQ_DEPTH];

	clockGen clkGen (
		.clk   (clk),
		.reset (reset)
	);

	storeExecPath uut (
		.clk             (clk),
		.reset           (reset),
		.recoverFlag_i   (recoverFlag),
		.backEndReady_i  (backEndReady),
		.ldValid_i       (ldValid),
		.ldLsqId_i       (ldLsqId),
		.ldAddr_i        (ldAddr),
		.ldSize_i        (ldSize),
		.ldAlId_i        (ldAlId),
		.ldPhyDest_i     (ldPhyDest),
		.loadDataValid_i (loadDataValid),
		.stValid_i       (stValid),
		.stLsqId_i       (stLsqId),
		.stAddr_i        (stAddr),
		.stSize_i        (stSize),
		.dispIsLoad_i    (dispIsLoad),
		.dispIsStore_i   (dispIsStore),
		.dispLdqId_i     (dispLdqId),
		.dispStqId_i     (dispStqId),
		.dispNextLd_i    (dispNextLd),
		.commitLdCount_i (commitLdCount),
		.commitLdIndex_i (commitLdIndex),
		.ldqHead_i       (ldqHead),
		.ldqTail_i       (ldqTail),
		.ldqCount_i      (ldqCount),
		.replayValid_o   (replayValid),
		.replayLsqId_o   (replayLsqId),
		.replayAddr_o    (replayAddr),
		.replaySize_o    (replaySize),
		.replayAlId_o    (replayAlId),
		.replayPhyDest_o (replayPhyDest),
		.vioValid_o      (vioValid),
		.vioAlId_o       (vioAlId)
	);

	bind storeExecPath storeExecPath_checker orderChecks (
		.clk           (clk),
		.reset         (reset),
		.recoverFlag_i (recoverFlag_i),
		.stValid_i     (stValid_i),
		.replayValid_i (replayValid_o),
		.vioValid_i    (vioValid_o)
	);

	task automatic abortRun(string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic compareValue(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
			abortRun("output mismatch against the reference model");
		end
	endtask

	// what squash clears, payload excluded
	task automatic clearState();
		mAddrValid   = '0;
		mWrittenBack = '0;
		for (int i = 0; i < `LSQ_DEPTH; i++)
		begin
			mAddr[i]   = '0;
			mSize[i]   = sizeByte;
			mNextLd[i] = '0;
		end
	endtask

	// larger access decides how many offset bits must agree
	function automatic logic accessesOverlap(logic [31:0] a, accessSizeT sa,
		logic [31:0] b, accessSizeT sb);
		accessSizeT wider;
		wider = (sa > sb) ? sa : sb;
		if (a[31:2] != b[31:2])
			return 1'b0;
		case (wider)
			sizeWord: return 1'b1;
			sizeHalf: return a[1] == b[1];
			default:  return a[1:0] == b[1:0];
		endcase
	endfunction

	// walk forward from nextLoad, window length is the distance to tail
	task automatic expectedViolation(output logic found, output alIdT alId);
		lsqIdxT nl;
		lsqIdxT idx;
		lsqIdxT tailDist;
		logic full;
		nl       = mNextLd[stLsqId];
		tailDist = lsqIdxT'(ldqTail - nl);
		full     = (ldqTail == nl) && (ldqHead == nl) && (ldqCount != '0);
		found    = 1'b0;
		alId     = '0;
		for (int j = 0; j < `LSQ_DEPTH; j++)
		begin
			idx = lsqIdxT'(nl + lsqIdxT'(j));
			if (!found && (full || j < int'(tailDist)) && mAddrValid[idx]
				&& mWrittenBack[idx] && accessesOverlap(stAddr.flat, stSize, mAddr[idx], mSize[idx]))
			begin
				found = 1'b1;
				alId  = mAlId[idx];
			end
		end
		found = found & stValid;
	endtask

	task automatic checkOutputs();
		logic expVio;
		alIdT expVioAlId;
		lsqIdxT head;
		head = ldqHead;
		expectedViolation(expVio, expVioAlId);
		compareValue("replayValid_o", 32'(replayValid),
			32'(mAddrValid[head] & ~mWrittenBack[head]));
		compareValue("replayLsqId_o", 32'(replayLsqId), 32'(head));
		compareValue("replayAddr_o", replayAddr.flat, mAddr[head]);
		compareValue("replaySize_o", 32'(replaySize), 32'(mSize[head]));
		compareValue("replayAlId_o", 32'(replayAlId), 32'(mAlId[head]));
		compareValue("replayPhyDest_o", 32'(replayPhyDest), 32'(mPhyDest[head]));
		compareValue("vioValid_o", 32'(vioValid), 32'(expVio));
		if (expVio)
			compareValue("vioAlId_o", 32'(vioAlId), 32'(expVioAlId));
	endtask

	// clears come after the load write so they win
	task automatic updateModel();
		if (recoverFlag)
		begin
			clearState();
		end
		else
		begin
			if (ldValid)
			begin
				mAddr[ldLsqId]        = ldAddr.flat;
				mSize[ldLsqId]        = ldSize;
				mAddrValid[ldLsqId]   = 1'b1;
				mWrittenBack[ldLsqId] = loadDataValid;
			end
			for (int l = 0; l < `DISPATCH_LANES; l++)
			begin
				if (backEndReady && dispIsLoad[l])
				begin
					mAddrValid[dispLdqId[l]]   = 1'b0;
					mWrittenBack[dispLdqId[l]] = 1'b0;
				end
				if (backEndReady && dispIsStore[l])
					mNextLd[dispStqId[l]] = dispNextLd[l];
			end
			for (int l = 0; l < `COMMIT_LANES; l++)
			begin
				if (l < int'(commitLdCount))
				begin
					mAddrValid[commitLdIndex[l]]   = 1'b0;
					mWrittenBack[commitLdIndex[l]] = 1'b0;
				end
			end
		end
		// payload keeps its contents through a squash
		if (ldValid)
		begin
			mAlId[ldLsqId]    = ldAlId;
			mPhyDest[ldLsqId] = ldPhyDest;
		end
	endtask

	task automatic idleInputs();
		recoverFlag   = 1'b0;
		backEndReady  = 1'b0;
		ldValid       = 1'b0;
		loadDataValid = 1'b0;
		stValid       = 1'b0;
		dispIsLoad    = '0;
		dispIsStore   = '0;
		commitLdCount = '0;
	endtask

	// check mid-cycle, follow the edge, drive again 1 ns later
	task automatic tick();
		#4;
		checkOutputs();
		@(posedge clk);
		updateModel();
		#1;
		idleInputs();
	endtask

	task automatic setPointers(lsqIdxT head, lsqIdxT tail, lsqCountT count);
		ldqHead  = head;
		ldqTail  = tail;
		ldqCount = count;
	endtask

	task automatic runLoad(lsqIdxT idx, logic [31:0] addr, accessSizeT size, logic dataValid);
		ldValid       = 1'b1;
		ldLsqId       = idx;
		ldAddr.flat   = addr;
		ldSize        = size;
		ldAlId        = alIdT'($urandom);
		ldPhyDest     = phyRegT'($urandom);
		loadDataValid = dataValid;
		tick();
	endtask

	task automatic runStore(lsqIdxT idx, logic [31:0] addr, accessSizeT size);
		stValid     = 1'b1;
		stLsqId     = idx;
		stAddr.flat = addr;
		stSize      = size;
		tick();
	endtask

	task automatic dispatchStore(lsqIdxT stq, lsqIdxT nextLd);
		backEndReady   = 1'b1;
		dispIsStore[0] = 1'b1;
		dispStqId[0]   = stq;
		dispNextLd[0]  = nextLd;
		tick();
	endtask

	task automatic dispatchLoad(lsqIdxT idx);
		backEndReady  = 1'b1;
		dispIsLoad[1] = 1'b1;
		dispLdqId[1]  = idx;
		tick();
	endtask

	task automatic commitLoads(commitCountT count, lsqIdxT first, lsqIdxT second);
		commitLdCount    = count;
		commitLdIndex[0] = first;
		commitLdIndex[1] = second;
		tick();
	endtask

	function automatic logic [31:0] randomAddr();
		// three words, so stores and loads collide often
		return 32'h7000 + ($urandom % 3) * 4 + ($urandom % 4);
	endfunction

	task automatic randomCycle();
		setPointers(lsqIdxT'($urandom), lsqIdxT'($urandom), lsqCountT'($urandom % 17));
		ldValid       = 1'($urandom);
		ldLsqId       = lsqIdxT'($urandom);
		ldAddr.flat   = randomAddr();
		ldSize        = accessSizeT'(2'($urandom % 3));
		ldAlId        = alIdT'($urandom);
		ldPhyDest     = phyRegT'($urandom);
		loadDataValid = 1'($urandom);
		stValid       = 1'($urandom);
		stLsqId       = lsqIdxT'($urandom);
		stAddr.flat   = randomAddr();
		stSize        = accessSizeT'(2'($urandom % 3));
		backEndReady  = 1'($urandom);
		for (int l = 0; l < `DISPATCH_LANES; l++)
		begin
			dispIsLoad[l]  = ($urandom % 3) == 0;
			dispIsStore[l] = ($urandom % 3) == 0;
			dispLdqId[l]   = lsqIdxT'($urandom);
			dispStqId[l]   = lsqIdxT'($urandom);
			dispNextLd[l]  = lsqIdxT'($urandom);
		end
		for (int l = 0; l < `COMMIT_LANES; l++)
		begin
			commitLdIndex[l] = lsqIdxT'($urandom);
		end
		commitLdCount = commitCountT'($urandom % 3);
		recoverFlag   = ($urandom % 40) == 0;
		tick();
	endtask

	task automatic waitResetRelease();
		int cycles;
		cycles = 0;
		while (reset !== 1'b0 && cycles < 20)
		begin
			@(posedge clk);
			cycles++;
		end
		if (reset !== 1'b0)
			abortRun("reset still asserted after 20 clock cycles");
		else
			#1;
	endtask

	initial
	begin
		void'($urandom(32'h757bcfb7));
		clearState();
		for (int i = 0; i < `LSQ_DEPTH; i++)
		begin
			mAlId[i]    = '0;
			mPhyDest[i] = '0;
		end
		idleInputs();
		ldLsqId   = '0;
		ldAddr    = '0;
		ldSize    = sizeByte;
		ldAlId    = '0;
		ldPhyDest = '0;
		stLsqId   = '0;
		stAddr    = '0;
		stSize    = sizeByte;
		for (int l = 0; l < `DISPATCH_LANES; l++)
		begin
			dispLdqId[l]  = '0;
			dispStqId[l]  = '0;
			dispNextLd[l] = '0;
		end
		commitLdIndex[0] = '0;
		commitLdIndex[1] = '0;
		setPointers(4'd0, 4'd0, 5'd0);
		waitResetRelease();

		// quiet queue, then a squash on it
		repeat (3) tick();
		recoverFlag = 1'b1;
		tick();
		tick();

		// head load without data replays, with data it does not
		setPointers(4'd2, 4'd6, 5'd4);
		runLoad(4'd2, 32'h0000_1004, sizeWord, 1'b0);
		tick();
		runLoad(4'd2, 32'h0000_1006, sizeHalf, 1'b1);
		tick();

		// every size pair and offset pair against one younger load
		dispatchStore(4'd3, 4'd2);
		for (int ls = 0; ls < 3; ls++)
		begin
			for (int ss = 0; ss < 3; ss++)
			begin
				for (int lo = 0; lo < 4; lo++)
				begin
					for (int so = 0; so < 4; so++)
					begin
						runLoad(4'd3, 32'h2000 + lo, accessSizeT'(2'(ls)), 1'b1);
						runStore(4'd3, 32'h2000 + so, accessSizeT'(2'(ss)));
					end
				end
			end
		end
		runStore(4'd3, 32'h2004, sizeWord);

		// older than nextLoad and past tail stay out of the window
		setPointers(4'd5, 4'd9, 5'd4);
		dispatchStore(4'd7, 4'd5);
		runLoad(4'd3, 32'h3000, sizeWord, 1'b1);
		runLoad(4'd10, 32'h3000, sizeWord, 1'b1);
		runStore(4'd7, 32'h3000, sizeByte);
		// two violators, nearest to nextLoad wins
		runLoad(4'd8, 32'h3002, sizeHalf, 1'b1);
		runLoad(4'd6, 32'h3000, sizeByte, 1'b1);
		runStore(4'd7, 32'h3000, sizeWord);

		// wrapped window 12 through 2
		setPointers(4'd12, 4'd3, 5'd7);
		dispatchStore(4'd8, 4'd12);
		runLoad(4'd1, 32'h4000, sizeWord, 1'b1);
		runLoad(4'd14, 32'h4001, sizeByte, 1'b1);
		runLoad(4'd5, 32'h4000, sizeWord, 1'b1);
		runStore(4'd8, 32'h4000, sizeWord);
		commitLoads(2'd1, 4'd14, 4'd0);
		runStore(4'd8, 32'h4000, sizeWord);

		// full queue, then the same pointers with nothing in it
		setPointers(4'd4, 4'd4, 5'd16);
		dispatchStore(4'd9, 4'd4);
		runLoad(4'd3, 32'h5000, sizeWord, 1'b1);
		runStore(4'd9, 32'h5000, sizeWord);
		setPointers(4'd4, 4'd4, 5'd0);
		runStore(4'd9, 32'h5000, sizeWord);

		// dispatch and commit both retire overlapping loads
		setPointers(4'd0, 4'd8, 5'd8);
		dispatchStore(4'd10, 4'd0);
		runLoad(4'd2, 32'h6000, sizeWord, 1'b1);
		runLoad(4'd5, 32'h6000, sizeWord, 1'b1);
		runLoad(4'd7, 32'h6000, sizeWord, 1'b1);
		runStore(4'd10, 32'h6000, sizeWord);
		dispatchLoad(4'd2);
		runStore(4'd10, 32'h6000, sizeWord);
		commitLoads(2'd2, 4'd5, 4'd7);
		runStore(4'd10, 32'h6000, sizeWord);

		// random traffic
		for (int n = 0; n < 400; n++)
		begin
			randomCycle();
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* compile.f */
+incdir+logic
logic/memAccessPkg.sv
logic/ldqPkg.sv
logic/ldqAddrCam.sv
logic/ldqStatus.sv
logic/ldqPayloadRam.sv
logic/followingLoadRam.sv
logic/violationDetect.sv
logic/storeExecPath.sv
test/clockGen.sv
test/storeExecPath_checker.sv
test/storeExecPath_tb.sv

/* run.sh */
#!/bin/bash
# build with Verilator and run, exit status follows the simulation
verilator --binary --timing --assert -f compile.f --top-module storeExecPath_tb -o simv \
	&& ./obj_dir/simv \
	|| exit 1
